/* build.f */
logic/sdr_pkg.sv
logic/tx_byte_buffer.sv
logic/scl_gen.sv
logic/sdr_frame_ctrl.sv
logic/sda_serializer.sv
logic/sdr_tx_top.sv
testbench/sdr_target_model.sv
testbench/sdr_tx_tb.sv

/* testbench/sdr_tx_tb.sv */
/*
 * testbench for the sdr controller transmit path
 * clock, reset, byte loading and start stimulus, target model hookup
 * reference bit stream function, compare process at o_done, reporting
 */
`timescale 1ns/1ps

module sdr_tx_tb;
    import sdr_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic         clk = 1'b0;
    logic         rst;
    logic         wr_en;
    sdr_byte_t    wr_data;
    logic         start;
    sdr_addr_t    addr;
    logic         sda;
    logic         scl;
    logic         sda_out;
    logic         sda_oe;
    logic         busy;
    logic         done;
    logic         nack;
    logic         target_ack;
    logic [127:0] cap_bits;
    logic [127:0] cap_oe;
    int           cap_len;
    int           start_cnt;
    int           stop_cnt;
    int           stray_cnt;

    // expectations set before each start
    sdr_byte_t    payload [BUF_DEPTH];
    logic [127:0] exp_bits;
    logic [127:0] exp_oe;
    int           exp_len;
    logic         exp_nack;
    int           exp_start;
    int           exp_stop;
    int           done_seen;

    int           seed = 95689;
    int           errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    always #4 clk = ~clk;

    sdr_tx_top sdr_tx_top_i (
        .i_sdr_clk (clk),
        .i_rst     (rst),
        .i_wr_en   (wr_en),
        .i_wr_data (wr_data),
        .i_start   (start),
        .i_addr    (addr),
        .i_sda_in  (sda),
        .o_scl     (scl),
        .o_sda_out (sda_out),
        .o_sda_oe  (sda_oe),
        .o_busy    (busy),
        .o_done    (done),
        .o_nack    (nack)
    );

    sdr_target_model target_i (
        .i_rst       (rst),
        .i_scl       (scl),
        .i_sda_out   (sda_out),
        .i_sda_oe    (sda_oe),
        .i_ack_en    (target_ack),
        .o_sda       (sda),
        .o_bits      (cap_bits),
        .o_oe_bits   (cap_oe),
        .o_bit_cnt   (cap_len),
        .o_start_cnt (start_cnt),
        .o_stop_cnt  (stop_cnt),
        .o_stray_cnt (stray_cnt)
    );

    // ========================================================================
    // reference bit stream of one private write
    // ========================================================================
    function automatic int expected_frame(
        input  sdr_addr_t    a,
        input  int           nbytes,
        input  logic         ack,
        output logic [127:0] bits,
        output logic [127:0] oes
    );
        int n;
        int i;
        int k;
        int ones;
        bits = '0;
        oes  = '0;
        n = 0;
        // address in open-drain, only zeros are driven
        for (i = 6; i >= 0; i--) begin
            bits[n] = a[i];
            oes[n]  = ~a[i];
            n++;
        end
        // rnw clear for a write
        bits[n] = 1'b0;
        oes[n]  = 1'b1;
        n++;
        // ack slot released by the controller and low when the target answers
        bits[n] = ~ack;
        n++;
        if (ack) begin
            for (k = 0; k < nbytes; k++) begin
                ones = 0;
                // data and t-bits driven push-pull
                for (i = 7; i >= 0; i--) begin
                    bits[n] = payload[k][i];
                    oes[n]  = 1'b1;
                    ones += payload[k][i];
                    n++;
                end
                // odd parity so byte plus t-bit hold an odd count of ones
                bits[n] = (ones % 2 == 0);
                oes[n]  = 1'b1;
                n++;
            end
        end
        return n;
    endfunction

    // ========================================================================
    // compare process for the cycle o_done is seen
    // ========================================================================
    always @(posedge clk) begin
        if (done === 1'b1) begin
            done_seen++;
            assert (cap_len == exp_len) else begin
                $display("FAIL cap_len: got %h expected %h", cap_len, exp_len);
                errors++;
            end
            assert (cap_bits == exp_bits) else begin
                $display("FAIL cap_bits: got %h expected %h", cap_bits, exp_bits);
                errors++;
            end
            assert (cap_oe == exp_oe) else begin
                $display("FAIL o_sda_oe: got %h expected %h", cap_oe, exp_oe);
                errors++;
            end
            assert (nack === exp_nack) else begin
                $display("FAIL o_nack: got %h expected %h", nack, exp_nack);
                errors++;
            end
            assert (start_cnt == exp_start && stop_cnt == exp_stop) else begin
                $display("missing or extra start or stop condition on the bus");
                errors++;
            end
            assert (stray_cnt == 0) else begin
                $display("scl rose outside a start to stop frame");
                errors++;
            end
        end
    end

    // inputs change 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input sdr_byte_t b);
        wr_en   = 1'b1;
        wr_data = b;
        tick();
        wr_en   = 1'b0;
    endtask

    task automatic load_bytes(input int nbytes);
        int k;
        int rnd;
        for (k = 0; k < nbytes; k++) begin
            rnd = $random(seed);
            payload[k] = rnd[7:0];
            write_byte(payload[k]);
        end
    endtask

    task automatic pulse_start(input sdr_addr_t a);
        start = 1'b1;
        addr  = a;
        tick();
        start = 1'b0;
    endtask

    // stray start and write while the transfer runs
    task automatic poke_while_busy();
        int cyc;
        for (cyc = 0; cyc < TIMEOUT_CYCLES && busy !== 1'b1; cyc++) begin
            tick();
        end
        if (busy !== 1'b1) begin
            $display("timeout waiting for o_busy to rise");
            errors++;
        end
        start   = 1'b1;
        addr    = 7'h2a;
        wr_en   = 1'b1;
        wr_data = 8'hc3;
        tick();
        start   = 1'b0;
        wr_en   = 1'b0;
    endtask

    task automatic wait_done();
        int   cyc;
        logic seen;
        seen = 1'b0;
        for (cyc = 0; cyc < TIMEOUT_CYCLES && !seen; cyc++) begin
            @(posedge clk);
            seen = (done === 1'b1);
        end
        #1;
        if (!seen) begin
            $display("timeout waiting for o_done");
            errors++;
        end
    endtask

    task automatic run_transfer(
        input string     name,
        input sdr_addr_t a,
        input int        nbytes,
        input logic      ack,
        input logic      overfill,
        input logic      poke
    );
        int   errs_before;
        int   rnd;
        errs_before = errors;
        target_ack  = ack;
        load_bytes(nbytes);
        if (overfill) begin
            rnd = $random(seed);
            write_byte(rnd[7:0]);
        end
        exp_len   = expected_frame(a, nbytes, ack, exp_bits, exp_oe);
        exp_nack  = ~ack;
        exp_start = start_cnt + 1;
        exp_stop  = stop_cnt + 1;
        done_seen = 0;
        pulse_start(a);
        if (poke) begin
            poke_while_busy();
        end
        wait_done();
        repeat (4) tick();
        // bus parked and o_done a single cycle
        assert (scl === 1'b1 && sda === 1'b1 && sda_oe === 1'b0 && busy === 1'b0) else begin
            $display("FAIL idle bus: o_scl %h sda %h o_sda_oe %h o_busy %h expected 1 1 0 0",
                     scl, sda, sda_oe, busy);
            errors++;
        end
        assert (done_seen == 1) else begin
            $display("o_done was high for %0d cycles instead of one", done_seen);
            errors++;
        end
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "failed");
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        int i;
        int rnd;
        int len;
        rst        = 1'b1;
        wr_en      = 1'b0;
        wr_data    = '0;
        start      = 1'b0;
        addr       = '0;
        target_ack = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        run_transfer("three bytes acked, start and stop", 7'h51, 3, 1'b1, 1'b0, 1'b0);
        run_transfer("nack skips data", 7'h3c, 2, 1'b0, 1'b0, 1'b0);
        run_transfer("one byte after nack", 7'h3c, 1, 1'b1, 1'b0, 1'b0);
        run_transfer("empty buffer", 7'h08, 0, 1'b1, 1'b0, 1'b0);
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            len = 1 + (rnd & 7);
            // last one fills the buffer and tries one more
            if (i == 7) begin
                run_transfer("full buffer, extra write", rnd[14:8], BUF_DEPTH, 1'b1, 1'b1, 1'b0);
            end else begin
                run_transfer("random length", rnd[14:8], len, 1'b1, 1'b0, 1'b0);
            end
        end
        run_transfer("start and write while busy", 7'h19, 4, 1'b1, 1'b0, 1'b1);
        run_transfer("transfer after busy", 7'h66, 2, 1'b1, 1'b0, 1'b0);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/sdr_target_model.sv */
/*
 * bus side target for the sdr transmit testbench
 * sda resolution with pull-up, start and stop detection
 * bit and controller drive enable capture per scl period
 * ack or nack answer in the ninth slot
 */
`timescale 1ns/1ps

module sdr_target_model (
    input  logic         i_rst,
    input  logic         i_scl,
    input  logic         i_sda_out,
    input  logic         i_sda_oe,
    input  logic         i_ack_en,
    output logic         o_sda,
    output logic [127:0] o_bits,
    output logic [127:0] o_oe_bits,
    output int           o_bit_cnt,
    output int           o_start_cnt,
    output int           o_stop_cnt,
    output int           o_stray_cnt
);
    // target holds sda low for the ack
    logic pull_low;
    logic in_frame;
    // bit seen at scl rise and kept until scl falls again
    logic pending;
    logic pend_bit;
    // controller drive enable seen with that bit
    logic pend_oe;

    // open-drain wired and with the pull-up when nobody drives
    assign o_sda = (i_sda_oe ? i_sda_out : 1'b1) & ~pull_low;

    initial begin
        pull_low    = 1'b0;
        in_frame    = 1'b0;
        pending     = 1'b0;
        pend_bit    = 1'b0;
        pend_oe     = 1'b0;
        o_bits      = '0;
        o_oe_bits   = '0;
        o_bit_cnt   = 0;
        o_start_cnt = 0;
        o_stop_cnt  = 0;
        o_stray_cnt = 0;
    end

    // start is sda falling with scl high
    always @(negedge o_sda) begin
        if (i_rst === 1'b0 && i_scl === 1'b1) begin
            in_frame  = 1'b1;
            pending   = 1'b0;
            o_bits    = '0;
            o_oe_bits = '0;
            o_bit_cnt = 0;
            o_start_cnt++;
        end
    end

    // stop is sda rising with scl high
    always @(posedge o_sda) begin
        if (i_rst === 1'b0 && i_scl === 1'b1) begin
            // the rise before a stop carries no bit
            in_frame = 1'b0;
            pending  = 1'b0;
            o_stop_cnt++;
        end
    end

    always @(posedge i_scl) begin
        if (i_rst === 1'b0) begin
            if (in_frame) begin
                pending  = 1'b1;
                pend_bit = o_sda;
                pend_oe  = i_sda_oe;
            end else begin
                o_stray_cnt++;
            end
        end
    end

    // a bit only counts once scl falls after it
    always @(negedge i_scl) begin
        if (i_rst === 1'b0 && in_frame && pending && o_bit_cnt < 128) begin
            o_bits[o_bit_cnt]    = pend_bit;
            o_oe_bits[o_bit_cnt] = pend_oe;
            o_bit_cnt++;
            pending = 1'b0;
        end
        // sda moves only while scl is already low
        #1;
        pull_low = i_ack_en && in_frame && (o_bit_cnt == 8);
    end

endmodule

/* logic/sdr_tx_top.sv */
/*
 * i3c sdr controller transmit path, private write only
 * byte buffer, frame fsm, scl generation and sda serializer
 */
`timescale 1ns/1ps
`default_nettype none

module sdr_tx_top (
    input  logic               i_sdr_clk,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  sdr_pkg::sdr_byte_t i_wr_data,
    input  logic               i_start,
    input  sdr_pkg::sdr_addr_t i_addr,
    input  logic               i_sda_in,
    output logic               o_scl,
    output logic               o_sda_out,
    output logic               o_sda_oe,
    output logic               o_busy,
    output logic               o_done,
    output logic               o_nack
);
    import sdr_pkg::*;

    // ========================================================================
    // internal wires
    // ========================================================================

    // buffer to fsm
    sdr_byte_t head;
    buf_cnt_t  count;
    logic      pop;
    logic      clear;

    // scl generation
    logic      run;
    logic      scl_rise;
    logic      scl_fall;

    // fsm to serializer
    ser_cmd_t  ser_cmd;
    logic      cmd_valid;
    logic      op_done;
    logic      ack_bit;

    // ========================================================================
    // blocks
    // ========================================================================

    tx_byte_buffer u_tx_byte_buffer (
        .i_sdr_clk (i_sdr_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_data (i_wr_data),
        .i_busy    (o_busy),
        .i_pop     (pop),
        .i_clear   (clear),
        .o_head    (head),
        .o_count   (count)
    );

    sdr_frame_ctrl u_sdr_frame_ctrl (
        .i_sdr_clk   (i_sdr_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_addr      (i_addr),
        .i_count     (count),
        .i_head      (head),
        .i_op_done   (op_done),
        .i_ack_bit   (ack_bit),
        .o_cmd       (ser_cmd),
        .o_cmd_valid (cmd_valid),
        .o_run       (run),
        .o_pop       (pop),
        .o_clear     (clear),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_nack      (o_nack)
    );

    scl_gen u_scl_gen (
        .i_sdr_clk  (i_sdr_clk),
        .i_rst      (i_rst),
        .i_run      (run),
        .o_scl      (o_scl),
        .o_scl_rise (scl_rise),
        .o_scl_fall (scl_fall)
    );

    sda_serializer u_sda_serializer (
        .i_sdr_clk   (i_sdr_clk),
        .i_rst       (i_rst),
        .i_cmd       (ser_cmd),
        .i_cmd_valid (cmd_valid),
        .i_scl_rise  (scl_rise),
        .i_scl_fall  (scl_fall),
        .i_sda_in    (i_sda_in),
        .o_sda_out   (o_sda_out),
        .o_sda_oe    (o_sda_oe),
        .o_op_done   (op_done),
        .o_ack_bit   (ack_bit)
    );

endmodule

`default_nettype wire

/* logic/sda_serializer.sv */
/*
 * sda serializer for the sdr controller
 * start and stop patterns, msb first byte shifting, t-bit, ack sampling
 * open-drain or push-pull drive per command
 */
`timescale 1ns/1ps
`default_nettype none

module sda_serializer (
    input  logic              i_sdr_clk,
    input  logic              i_rst,
    input  sdr_pkg::ser_cmd_t i_cmd,
    input  logic              i_cmd_valid,
    input  logic              i_scl_rise,
    input  logic              i_scl_fall,
    input  logic              i_sda_in,
    output logic              o_sda_out,
    output logic              o_sda_oe,
    output logic              o_op_done,
    output logic              o_ack_bit
);
    import sdr_pkg::*;

    ser_op_e    op_q;
    logic       pp_q;
    sdr_byte_t  shreg;
    logic [2:0] bit_cnt;
    // a bit of the current op is on the bus
    logic       bit_out;
    // half period hold for start and stop edges
    logic       hold_run;
    logic [$clog2(SCL_HALF_CYCLES)-1:0] hold_cnt;

    always_ff @(posedge i_sdr_clk) begin
        if (i_rst) begin
            op_q      <= SER_IDLE;
            pp_q      <= 1'b0;
            bit_cnt   <= '0;
            bit_out   <= 1'b0;
            hold_run  <= 1'b0;
            hold_cnt  <= '0;
            o_sda_out <= 1'b1;
            o_sda_oe  <= 1'b0;
            o_op_done <= 1'b0;
            o_ack_bit <= 1'b0;
        end else begin
            o_op_done <= 1'b0;
            if (i_cmd_valid) begin
                op_q     <= i_cmd.op;
                pp_q     <= i_cmd.pp;
                shreg    <= i_cmd.data;
                bit_cnt  <= '0;
                bit_out  <= 1'b0;
                hold_cnt <= '0;
                hold_run <= (i_cmd.op == SER_START);
                // start, sda falls while scl still idles high
                if (i_cmd.op == SER_START) begin
                    o_sda_oe  <= 1'b1;
                    o_sda_out <= 1'b0;
                end
            end else if (hold_run) begin
                if (hold_cnt == SCL_HALF_CYCLES - 1) begin
                    hold_run  <= 1'b0;
                    bit_out   <= 1'b0;
                    o_op_done <= 1'b1;
                    op_q      <= SER_IDLE;
                    // end of stop, sda rises with scl high
                    if (op_q == SER_STOP) begin
                        o_sda_oe  <= 1'b0;
                        o_sda_out <= 1'b1;
                    end
                end else begin
                    hold_cnt <= hold_cnt + 1'b1;
                end
            end else if (i_scl_fall) begin
                // new bit goes out in scl low
                case (op_q)
                    SER_BYTE, SER_TBIT: begin
                        bit_out   <= 1'b1;
                        o_sda_oe  <= pp_q | ~shreg[7];
                        o_sda_out <= pp_q & shreg[7];
                        shreg     <= {shreg[6:0], 1'b0};
                        bit_cnt   <= bit_cnt + 1'b1;
                    end
                    SER_ACK: begin
                        // line released for the target
                        bit_out   <= 1'b1;
                        o_sda_oe  <= 1'b0;
                        o_sda_out <= 1'b1;
                    end
                    SER_STOP: begin
                        bit_out   <= 1'b1;
                        o_sda_oe  <= 1'b1;
                        o_sda_out <= 1'b0;
                    end
                    default: begin
                        bit_out <= 1'b0;
                    end
                endcase
            end else if (i_scl_rise && bit_out) begin
                if (op_q == SER_STOP) begin
                    hold_run <= 1'b1;
                end else if (op_q != SER_BYTE || bit_cnt == 3'd0) begin
                    // bit_cnt wraps to 0 after the eighth bit
                    o_op_done <= 1'b1;
                    op_q      <= SER_IDLE;
                    bit_out   <= 1'b0;
                    if (op_q == SER_ACK) begin
                        o_ack_bit <= i_sda_in;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sdr_frame_ctrl.sv */
/*
 * private write transaction fsm
 * start, address with rnw 0, ack, data bytes with t-bits, stop
 * frame counter against the buffered byte count, odd parity t-bit
 */
`timescale 1ns/1ps
`default_nettype none

module sdr_frame_ctrl (
    input  logic               i_sdr_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  sdr_pkg::sdr_addr_t i_addr,
    input  sdr_pkg::buf_cnt_t  i_count,
    input  sdr_pkg::sdr_byte_t i_head,
    input  logic               i_op_done,
    input  logic               i_ack_bit,
    output sdr_pkg::ser_cmd_t  o_cmd,
    output logic               o_cmd_valid,
    output logic               o_run,
    output logic               o_pop,
    output logic               o_clear,
    output logic               o_busy,
    output logic               o_done,
    output logic               o_nack
);
    import sdr_pkg::*;

    ctrl_state_e state;
    sdr_addr_t   addr_q;
    // frame counter, data bytes already sent
    buf_cnt_t    sent_cnt;
    // current byte op carries the address
    logic        addr_phase;
    // ack bit kept until the stop is done
    logic        ack_q;
    logic        last_frame;

    assign last_frame = (sent_cnt == i_count);

    function automatic ser_cmd_t make_cmd(
        input ser_op_e   op,
        input sdr_byte_t data,
        input logic      pp
    );
        ser_cmd_t c;
        c.op   = op;
        c.data = data;
        c.pp   = pp;
        return c;
    endfunction

    // ========================================================================
    // transaction fsm, one command issued on entry to each state
    // ========================================================================
    always_ff @(posedge i_sdr_clk) begin
        if (i_rst) begin
            state       <= ST_IDLE;
            o_cmd       <= make_cmd(SER_IDLE, '0, 1'b0);
            o_cmd_valid <= 1'b0;
            o_run       <= 1'b0;
            o_pop       <= 1'b0;
            o_clear     <= 1'b0;
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
            o_nack      <= 1'b0;
            sent_cnt    <= '0;
            addr_phase  <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            // strobes
            o_cmd_valid <= 1'b0;
            o_pop       <= 1'b0;
            o_clear     <= 1'b0;
            o_done      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        addr_q      <= i_addr;
                        sent_cnt    <= '0;
                        ack_q       <= 1'b0;
                        o_busy      <= 1'b1;
                        o_nack      <= 1'b0;
                        o_cmd       <= make_cmd(SER_START, '0, 1'b0);
                        o_cmd_valid <= 1'b1;
                        state       <= ST_START;
                    end
                end
                ST_START: begin
                    // sda low with scl high, now start clocking
                    if (i_op_done) begin
                        o_run       <= 1'b1;
                        addr_phase  <= 1'b1;
                        o_cmd       <= make_cmd(SER_BYTE, {addr_q, 1'b0}, 1'b0);
                        o_cmd_valid <= 1'b1;
                        state       <= ST_BYTE;
                    end
                end
                ST_BYTE: begin
                    if (i_op_done && addr_phase) begin
                        addr_phase  <= 1'b0;
                        o_cmd       <= make_cmd(SER_ACK, '0, 1'b0);
                        o_cmd_valid <= 1'b1;
                        state       <= ST_ACK;
                    end else if (i_op_done) begin
                        // odd parity over the byte just sent, in the msb slot
                        o_pop       <= 1'b1;
                        sent_cnt    <= sent_cnt + 1'b1;
                        o_cmd       <= make_cmd(SER_TBIT, {~^o_cmd.data, 7'd0}, 1'b1);
                        o_cmd_valid <= 1'b1;
                        state       <= ST_TBIT;
                    end
                end
                ST_ACK, ST_TBIT: begin
                    if (i_op_done) begin
                        if (state == ST_ACK) begin
                            ack_q <= i_ack_bit;
                        end
                        o_cmd_valid <= 1'b1;
                        // nack or no bytes left ends the frame
                        if (last_frame || (state == ST_ACK && i_ack_bit)) begin
                            o_run <= 1'b0;
                            o_cmd <= make_cmd(SER_STOP, '0, 1'b0);
                            state <= ST_STOP;
                        end else begin
                            o_cmd <= make_cmd(SER_BYTE, i_head, 1'b1);
                            state <= ST_BYTE;
                        end
                    end
                end
                ST_STOP: begin
                    if (i_op_done) begin
                        o_done  <= 1'b1;
                        o_clear <= 1'b1;
                        o_busy  <= 1'b0;
                        o_nack  <= ack_q;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/scl_gen.sv */
/*
 * scl generation for the sdr controller
 * half period counter, level and one cycle edge pulses
 */
`timescale 1ns/1ps
`default_nettype none

module scl_gen (
    input  logic i_sdr_clk,
    input  logic i_rst,
    input  logic i_run,
    output logic o_scl,
    output logic o_scl_rise,
    output logic o_scl_fall
);
    import sdr_pkg::*;

    logic [$clog2(SCL_HALF_CYCLES)-1:0] half_cnt;
    // clock running, stays set after run drops until scl is back high
    logic                               active;

    always_ff @(posedge i_sdr_clk) begin
        if (i_rst) begin
            o_scl      <= 1'b1;
            o_scl_rise <= 1'b0;
            o_scl_fall <= 1'b0;
            active     <= 1'b0;
            half_cnt   <= '0;
        end else begin
            o_scl_rise <= 1'b0;
            o_scl_fall <= 1'b0;
            if (i_run || active) begin
                active <= 1'b1;
                if (half_cnt == SCL_HALF_CYCLES - 1) begin
                    half_cnt <= '0;
                    o_scl    <= ~o_scl;
                    // pulses line up with the new level
                    if (o_scl) begin
                        o_scl_fall <= 1'b1;
                    end else begin
                        o_scl_rise <= 1'b1;
                        // run gone, park scl high here
                        if (!i_run) begin
                            active <= 1'b0;
                        end
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tx_byte_buffer.sv */
/*
 * payload byte buffer for the private write
 * host writes bytes in order, controller pops them as they go out
 * cleared as a whole once the transfer ends
 */
`timescale 1ns/1ps
`default_nettype none

module tx_byte_buffer (
    input  logic               i_sdr_clk,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  sdr_pkg::sdr_byte_t i_wr_data,
    input  logic               i_busy,
    input  logic               i_pop,
    input  logic               i_clear,
    output sdr_pkg::sdr_byte_t o_head,
    output sdr_pkg::buf_cnt_t  o_count
);
    import sdr_pkg::*;

    sdr_byte_t mem [BUF_DEPTH];
    buf_cnt_t  wr_ptr;
    buf_cnt_t  rd_ptr;
    logic      full;
    logic      wr_ok;

    assign full = (wr_ptr == buf_cnt_t'(BUF_DEPTH));
    // host writes dropped during a transfer, when full, or on clear
    assign wr_ok = i_wr_en && !i_busy && !full && !i_clear;

    // storage
    always_ff @(posedge i_sdr_clk) begin
        if (wr_ok) begin
            mem[wr_ptr[$clog2(BUF_DEPTH)-1:0]] <= i_wr_data;
        end
    end

    // pointers, clear empties the whole buffer
    always_ff @(posedge i_sdr_clk) begin
        if (i_rst || i_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // no pop past the last written byte
            if (i_pop && (rd_ptr != wr_ptr)) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head byte and number written so far
    assign o_head  = mem[rd_ptr[$clog2(BUF_DEPTH)-1:0]];
    assign o_count = wr_ptr;

endmodule

`default_nettype wire

/* logic/sdr_pkg.sv */
/*
 * shared definitions for the i3c sdr controller transmit path
 * bus timing and payload buffer sizing
 * vector types for bytes, addresses and buffer counts
 * serializer op and controller state encodings, serializer command
 */
package sdr_pkg;

    // ========================================================================
    // timing and sizing
    // ========================================================================

    // system clocks per scl half period, full period is twice this
    localparam int SCL_HALF_CYCLES = 3;
    // payload bytes held for one private write
    localparam int BUF_DEPTH = 8;
    // wide enough for counts 0..BUF_DEPTH
    localparam int BUF_PTR_W = 4;

    // ========================================================================
    // types
    // ========================================================================

    typedef logic [7:0]           sdr_byte_t;
    typedef logic [6:0]           sdr_addr_t;
    typedef logic [BUF_PTR_W-1:0] buf_cnt_t;

    // one bus operation handed to the serializer
    typedef enum logic [2:0] {
        SER_IDLE  = 3'd0,
        SER_START = 3'd1,
        SER_BYTE  = 3'd2,
        SER_TBIT  = 3'd3,
        SER_ACK   = 3'd4,
        SER_STOP  = 3'd5
    } ser_op_e;

    // transaction fsm, one state per serializer op
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1,
        ST_BYTE  = 3'd2,
        ST_TBIT  = 3'd3,
        ST_ACK   = 3'd4,
        ST_STOP  = 3'd5
    } ctrl_state_e;

    // pp set selects push-pull, cleared means open-drain
    typedef struct packed {
        ser_op_e   op;
        sdr_byte_t data;
        logic      pp;
    } ser_cmd_t;

endpackage
